//--- rtl/dmac_cfg_pkg.sv
package dmac_cfg_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int LEN_BITS   = 4;   // L means L+1 beats
    localparam int SIZE_BITS  = 3;
    localparam int ID_BITS    = 4;

    // Transaction IDs
    localparam logic [ID_BITS-1:0] ID_DMA2MEM = 4'd1;
    localparam logic [ID_BITS-1:0] ID_DMA2AES = 4'd2;
    localparam logic [ID_BITS-1:0] ID_DMA_RD  = 4'd3;

    // Region code sits in dst_addr[19:16]
    localparam logic [3:0] DST_MEM_REGION = 4'h0;
    localparam logic [3:0] DST_AES_REGION = 4'h2;

    localparam int FIFO_DEPTH = 16;

    // One block move, given with the start strobe
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] src_addr;
        logic [ADDR_WIDTH-1:0] dst_addr;
        logic [LEN_BITS-1:0]   len;
        logic [SIZE_BITS-1:0]  size;
        logic [1:0]            burst;
    } dmac_cmd_t;

endpackage

//--- rtl/dmac_axi_pkg.sv
package dmac_axi_pkg;

    typedef struct packed {
        logic [dmac_cfg_pkg::ID_BITS-1:0]    id;
        logic [dmac_cfg_pkg::ADDR_WIDTH-1:0] addr;
        logic [dmac_cfg_pkg::LEN_BITS-1:0]   len;
        logic [dmac_cfg_pkg::SIZE_BITS-1:0]  size;
        logic [1:0]                          burst;
        logic                                valid;
    } axi_ar_t;

    typedef struct packed {
        logic [dmac_cfg_pkg::ID_BITS-1:0]    id;
        logic [dmac_cfg_pkg::DATA_WIDTH-1:0] data;
        logic [1:0]                          resp;
        logic                                last;
        logic                                valid;
    } axi_r_t;

    typedef struct packed {
        logic [dmac_cfg_pkg::ID_BITS-1:0]    id;
        logic [dmac_cfg_pkg::ADDR_WIDTH-1:0] addr;
        logic [dmac_cfg_pkg::LEN_BITS-1:0]   len;
        logic [dmac_cfg_pkg::SIZE_BITS-1:0]  size;
        logic [1:0]                          burst;
        logic                                valid;
    } axi_aw_t;

    typedef struct packed {
        logic [dmac_cfg_pkg::DATA_WIDTH-1:0]   data;
        logic [dmac_cfg_pkg::DATA_WIDTH/8-1:0] strb;
        logic                                  last;
        logic                                  valid;
    } axi_w_t;

    typedef struct packed {
        logic [dmac_cfg_pkg::ID_BITS-1:0] id;
        logic [1:0]                       resp;
        logic                             valid;
    } axi_b_t;

    // Master side
    typedef struct packed {
        axi_ar_t ar;
        axi_aw_t aw;
        axi_w_t  w;
        logic    rready;
        logic    bready;
    } axi_req_t;

    // Slave side
    typedef struct packed {
        axi_r_t r;
        axi_b_t b;
        logic   arready;
        logic   awready;
        logic   wready;
    } axi_rsp_t;

endpackage

//--- rtl/dmac_fifo.sv
`timescale 1ns/100ps

module dmac_fifo (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                push_i,
    input  logic [dmac_cfg_pkg::DATA_WIDTH-1:0] push_data_i,
    input  logic                                pop_i,
    output logic [dmac_cfg_pkg::DATA_WIDTH-1:0] data_o,
    output logic                                empty_o,
    output logic                                full_o
);

    logic [dmac_cfg_pkg::DATA_WIDTH-1:0] mem [dmac_cfg_pkg::FIFO_DEPTH];

    logic [$clog2(dmac_cfg_pkg::FIFO_DEPTH)-1:0]   wr_ptr, rd_ptr;  // Wrap on power of two
    logic [$clog2(dmac_cfg_pkg::FIFO_DEPTH+1)-1:0] count;

    logic do_push, do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign data_o  = mem[rd_ptr];  // Fall-through head
    assign empty_o = (count == 0);
    assign full_o  = (count == dmac_cfg_pkg::FIFO_DEPTH);

endmodule

//--- rtl/dmac_read.sv
`timescale 1ns/100ps

module dmac_read (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  start_i,
    input  dmac_cfg_pkg::dmac_cmd_t               cmd_i,
    input  logic                                  arready_i,
    input  dmac_axi_pkg::axi_r_t                  r_i,
    input  logic                                  fifo_full_i,
    output dmac_axi_pkg::axi_ar_t                 ar_o,
    output logic                                  rready_o,
    output logic                                  push_o,
    output logic [dmac_cfg_pkg::DATA_WIDTH-1:0]   push_data_o
);

    typedef enum logic [1:0] {
        IDLE,
        AR,
        R
    } state_t;

    state_t state_q, state_d;

    logic [dmac_cfg_pkg::ADDR_WIDTH-1:0] src_addr_q;
    logic [dmac_cfg_pkg::LEN_BITS-1:0]   len_q;
    logic [dmac_cfg_pkg::SIZE_BITS-1:0]  size_q;
    logic [1:0]                          burst_q;

    logic r_hs;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Source side of the command
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            src_addr_q <= cmd_i.src_addr;
            len_q      <= cmd_i.len;
            size_q     <= cmd_i.size;
            burst_q    <= cmd_i.burst;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start_i) state_d = AR;
            AR:   if (ar_o.valid && arready_i) state_d = R;
            R:    if (r_hs && r_i.last) state_d = IDLE;  // Single burst done
            default: state_d = IDLE;
        endcase
    end

    assign ar_o.id    = dmac_cfg_pkg::ID_DMA_RD;
    assign ar_o.addr  = src_addr_q;
    assign ar_o.len   = len_q;
    assign ar_o.size  = size_q;
    assign ar_o.burst = burst_q;
    assign ar_o.valid = (state_q == AR);

    // Stall R while the FIFO has no room
    assign rready_o    = (state_q == R) && !fifo_full_i;
    assign r_hs        = r_i.valid && rready_o;
    assign push_o      = r_hs;
    assign push_data_o = r_i.data;

endmodule

//--- rtl/dmac_write.sv
`timescale 1ns/100ps

module dmac_write (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                start_i,
    input  dmac_cfg_pkg::dmac_cmd_t             cmd_i,
    input  logic [dmac_cfg_pkg::DATA_WIDTH-1:0] fifo_data_i,
    input  logic                                fifo_empty_i,
    input  logic                                awready_i,
    input  logic                                wready_i,
    input  dmac_axi_pkg::axi_b_t                b_i,
    output dmac_axi_pkg::axi_aw_t               aw_o,
    output dmac_axi_pkg::axi_w_t                w_o,
    output logic                                bready_o,
    output logic                                pop_o,
    output logic                                intr_o,
    output logic                                busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        WA,
        W,
        B
    } state_t;

    state_t state_q, state_d;

    logic [dmac_cfg_pkg::ADDR_WIDTH-1:0] dst_addr_q;
    logic [dmac_cfg_pkg::LEN_BITS-1:0]   len_q;
    logic [dmac_cfg_pkg::SIZE_BITS-1:0]  size_q;
    logic [1:0]                          burst_q;

    logic [dmac_cfg_pkg::LEN_BITS-1:0] beat_cnt;
    logic [3:0]                        region;
    logic                              w_hs;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            dst_addr_q <= cmd_i.dst_addr;
            len_q      <= cmd_i.len;
            size_q     <= cmd_i.size;
            burst_q    <= cmd_i.burst;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start_i) state_d = WA;
            WA:   if (aw_o.valid && awready_i) state_d = W;
            W:    if (w_hs && w_o.last) state_d = B;
            B:    if (b_i.valid && bready_o) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // Beats sent so far in this burst
    always_ff @(posedge clk_i) begin
        if (!rst_ni || state_q == IDLE) begin
            beat_cnt <= '0;
        end else if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign region = dst_addr_q[19:16];

    assign aw_o.id    = (region == dmac_cfg_pkg::DST_MEM_REGION) ? dmac_cfg_pkg::ID_DMA2MEM :
                        (region == dmac_cfg_pkg::DST_AES_REGION) ? dmac_cfg_pkg::ID_DMA2AES :
                        '0;
    assign aw_o.addr  = dst_addr_q;
    assign aw_o.len   = len_q;
    assign aw_o.size  = size_q;
    assign aw_o.burst = burst_q;
    assign aw_o.valid = (state_q == WA);

    assign w_o.data  = (state_q == W) ? fifo_data_i : '0;
    assign w_o.strb  = '1;  // Full words only
    assign w_o.last  = (state_q == W) && (beat_cnt == len_q);
    assign w_o.valid = (state_q == W) && !fifo_empty_i;
    assign w_hs      = w_o.valid && wready_i;

    assign pop_o    = (state_q == W) && wready_i && !fifo_empty_i;
    assign bready_o = (state_q == B);
    assign intr_o   = (state_q == B) && b_i.valid;
    assign busy_o   = (state_q != IDLE);

endmodule

//--- rtl/dmac_top.sv
`timescale 1ns/100ps

module dmac_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     start_i,
    input  dmac_cfg_pkg::dmac_cmd_t  cmd_i,
    input  dmac_axi_pkg::axi_rsp_t   bus_rsp_i,
    output dmac_axi_pkg::axi_req_t   bus_req_o,
    output logic                     intr_o,
    output logic                     busy_o
);

    logic                                push, pop;
    logic [dmac_cfg_pkg::DATA_WIDTH-1:0] push_data, fifo_data;
    logic                                fifo_empty, fifo_full;

    // Reader may idle early, so a start during busy must not reach it
    dmac_read u_read (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i && !busy_o),
        .cmd_i       (cmd_i),
        .arready_i   (bus_rsp_i.arready),
        .r_i         (bus_rsp_i.r),
        .fifo_full_i (fifo_full),
        .ar_o        (bus_req_o.ar),
        .rready_o    (bus_req_o.rready),
        .push_o      (push),
        .push_data_o (push_data)
    );

    dmac_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .data_o      (fifo_data),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full)
    );

    dmac_write u_write (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start_i),
        .cmd_i        (cmd_i),
        .fifo_data_i  (fifo_data),
        .fifo_empty_i (fifo_empty),
        .awready_i    (bus_rsp_i.awready),
        .wready_i     (bus_rsp_i.wready),
        .b_i          (bus_rsp_i.b),
        .aw_o         (bus_req_o.aw),
        .w_o          (bus_req_o.w),
        .bready_o     (bus_req_o.bready),
        .pop_o        (pop),
        .intr_o       (intr_o),
        .busy_o       (busy_o)
    );

endmodule

//--- tests/dmac_tb.sv
`timescale 1ns/100ps

module dmac_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_XFER   = 8;
    localparam int TIMEOUT_NS = (NUM_XFER * 16 * 2 * 8 + 10) * CLK_PERIOD;
    localparam logic [3:0] REGIONS [3] = '{4'h0, 4'h2, 4'h7};  // Mem, AES, other

    logic                    clk_i;
    logic                    rst_ni;
    logic                    start_i;
    dmac_cfg_pkg::dmac_cmd_t cmd_i;
    dmac_axi_pkg::axi_rsp_t  bus_rsp_i;
    dmac_axi_pkg::axi_req_t  bus_req_o;
    logic                    intr_o;
    logic                    busy_o;

    integer                  seed = 32'he17e_4926;
    int unsigned             value_errs = 0, other_errs = 0;
    int unsigned             ar_cnt = 0, aw_cnt = 0, intr_cnt = 0;
    dmac_cfg_pkg::dmac_cmd_t cur_cmd;
    logic [4:0]              wbeat;  // W beats seen in this transfer
    logic                    rst_seen = 1'b0, rst_d = 1'b0;

    // Slave read and write state
    logic [31:0] rd_addr;
    logic [3:0]  rd_left, rd_id;
    logic        rd_active = 1'b0, r_hs_q = 1'b0, b_pending = 1'b0;

    logic        ar_hs, aw_hs, w_hs, r_hs, b_hs, ctrl_active;
    logic [31:0] exp_data;
    logic [4:0]  exp_beats;
    logic [63:0] ar_exp, ar_act, aw_exp, aw_act, w_exp, w_act;

    dmac_top DUT (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .start_i   (start_i),
        .cmd_i     (cmd_i),
        .bus_rsp_i (bus_rsp_i),
        .bus_req_o (bus_req_o),
        .intr_o    (intr_o),
        .busy_o    (busy_o)
    );

    function automatic logic ready_draw();
        return (32'($random(seed)) & 32'd3) != 32'd0;  // About 3 in 4
    endfunction

    function automatic logic [3:0] aw_id_for(input logic [31:0] dst);
        case (dst[19:16])
            dmac_cfg_pkg::DST_MEM_REGION: return dmac_cfg_pkg::ID_DMA2MEM;
            dmac_cfg_pkg::DST_AES_REGION: return dmac_cfg_pkg::ID_DMA2AES;
            default: return 4'd0;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        value_errs++;
        $display("Fail %s: expected %h, actual %h at %0t", name, exp, act, $time);
    endtask

    task automatic report_other(input string what);
        other_errs++;
        $display("Error: %s at %0t", what, $time);
    endtask

    assign ar_hs = bus_req_o.ar.valid && bus_rsp_i.arready;
    assign aw_hs = bus_req_o.aw.valid && bus_rsp_i.awready;
    assign w_hs  = bus_req_o.w.valid && bus_rsp_i.wready;
    assign r_hs  = bus_rsp_i.r.valid && bus_req_o.rready;
    assign b_hs  = bus_rsp_i.b.valid && bus_req_o.bready;

    assign ctrl_active = bus_req_o.ar.valid || bus_req_o.aw.valid || bus_req_o.w.valid
                       || bus_req_o.rready || bus_req_o.bready || intr_o || busy_o;

    assign exp_data  = (cur_cmd.src_addr + 32'({wbeat, 2'b00})) ^ 32'h5a5a_0000;
    assign exp_beats = {1'b0, cur_cmd.len} + 5'd1;
    assign ar_exp = 64'({dmac_cfg_pkg::ID_DMA_RD, cur_cmd.src_addr, cur_cmd.len,
                         cur_cmd.size, cur_cmd.burst});
    assign ar_act = 64'({bus_req_o.ar.id, bus_req_o.ar.addr, bus_req_o.ar.len,
                         bus_req_o.ar.size, bus_req_o.ar.burst});
    assign aw_exp = 64'({aw_id_for(cur_cmd.dst_addr), cur_cmd.dst_addr, cur_cmd.len,
                         cur_cmd.size, cur_cmd.burst});
    assign aw_act = 64'({bus_req_o.aw.id, bus_req_o.aw.addr, bus_req_o.aw.len,
                         bus_req_o.aw.size, bus_req_o.aw.burst});
    assign w_exp  = 64'({exp_data, 4'hf, wbeat == {1'b0, cur_cmd.len}});
    assign w_act  = 64'({bus_req_o.w.data, bus_req_o.w.strb, bus_req_o.w.last});

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Reference state of the running transfer
    always @(posedge clk_i) begin
        rst_seen <= rst_seen || !rst_ni;
        rst_d    <= rst_ni;
        if (start_i && !busy_o) begin
            cur_cmd <= cmd_i;
            wbeat   <= '0;
        end else if (w_hs) begin
            wbeat <= wbeat + 5'd1;
        end
        if (ar_hs) ar_cnt <= ar_cnt + 1;
        if (aw_hs) aw_cnt <= aw_cnt + 1;
        if (intr_o) intr_cnt <= intr_cnt + 1;
    end

    always @(posedge clk_i) begin
        r_hs_q <= r_hs;
        if (ar_hs) begin
            rd_addr   <= bus_req_o.ar.addr;
            rd_left   <= bus_req_o.ar.len;
            rd_id     <= bus_req_o.ar.id;
            rd_active <= 1'b1;
        end else if (r_hs) begin
            rd_addr   <= rd_addr + 32'd4;
            rd_left   <= rd_left - 4'd1;
            rd_active <= !bus_rsp_i.r.last;
        end
        if (w_hs && bus_req_o.w.last) b_pending <= 1'b1;
        else if (b_hs) b_pending <= 1'b0;
    end

    // Slave outputs change on the falling edge only
    initial begin
        bus_rsp_i = '0;
        forever begin
            @(negedge clk_i);
            bus_rsp_i.arready = ready_draw();
            bus_rsp_i.awready = ready_draw();
            bus_rsp_i.wready  = ready_draw();
            bus_rsp_i.r.valid = rd_active && ((bus_rsp_i.r.valid && !r_hs_q) || ready_draw());
            bus_rsp_i.r.data  = rd_addr ^ 32'h5a5a_0000;
            bus_rsp_i.r.last  = (rd_left == 4'd0);
            bus_rsp_i.r.id    = rd_id;
            bus_rsp_i.r.resp  = 2'b00;
            bus_rsp_i.b.valid = b_pending;
            bus_rsp_i.b.id    = bus_req_o.aw.id;
            bus_rsp_i.b.resp  = 2'b00;
        end
    end

    reset_quiet: assert property (@(posedge clk_i)
        rst_seen && (!rst_ni || !rst_d) |-> !ctrl_active)
        else report_other("control output active during or just after reset");
    ar_fields: assert property (@(posedge clk_i) disable iff (!rst_ni) ar_hs |-> ar_act == ar_exp)
        else report_value("ar_fields", $sampled(ar_exp), $sampled(ar_act));
    aw_fields: assert property (@(posedge clk_i) disable iff (!rst_ni) aw_hs |-> aw_act == aw_exp)
        else report_value("aw_fields", $sampled(aw_exp), $sampled(aw_act));
    w_beat: assert property (@(posedge clk_i) disable iff (!rst_ni) w_hs |-> w_act == w_exp)
        else report_value("w_beat", $sampled(w_exp), $sampled(w_act));
    beat_count: assert property (@(posedge clk_i) disable iff (!rst_ni) b_hs |-> wbeat == exp_beats)
        else report_value("beat_count", 64'($sampled(exp_beats)), 64'($sampled(wbeat)));
    intr_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) intr_o == b_hs)
        else report_value("intr_pulse", 64'($sampled(b_hs)), 64'($sampled(intr_o)));
    busy_after: assert property (@(posedge clk_i) disable iff (!rst_ni) b_hs |=> !busy_o)
        else report_other("busy still high after the B handshake");
    ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_req_o.ar.valid && !bus_rsp_i.arready |=> $stable(bus_req_o.ar))
        else report_other("AR channel changed while stalled");
    aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_req_o.aw.valid && !bus_rsp_i.awready |=> $stable(bus_req_o.aw))
        else report_other("AW channel changed while stalled");
    w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_req_o.w.valid && !bus_rsp_i.wready |=> $stable(bus_req_o.w))
        else report_other("W channel changed while stalled");

    initial begin
        dmac_cfg_pkg::dmac_cmd_t cmd;
        int unsigned             gap;
        rst_ni  = 1'b0;
        start_i = 1'b0;
        cmd_i   = '0;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (2) @(negedge clk_i);
        for (int i = 0; i < NUM_XFER; i++) begin
            cmd.src_addr = 32'($random(seed)) & 32'h00ff_fffc;
            cmd.dst_addr = {12'h000, REGIONS[i % 3], 16'($random(seed)) & 16'hfffc};
            cmd.len      = 4'($random(seed));
            cmd.size     = 3'd2;
            cmd.burst    = 2'b01;  // INCR
            cmd_i   = cmd;
            start_i = 1'b1;
            @(negedge clk_i);
            start_i = 1'b0;
            gap = 32'($random(seed)) & 32'd3;
            repeat (gap + 1) @(negedge clk_i);
            if (busy_o) begin  // Stray command, must be dropped
                cmd_i   = ~cmd;
                start_i = 1'b1;
                @(negedge clk_i);
                start_i = 1'b0;
            end
            wait (intr_cnt == i + 1);
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        ar_total: assert (ar_cnt == NUM_XFER) else report_value("ar_count", NUM_XFER, ar_cnt);
        aw_total: assert (aw_cnt == NUM_XFER) else report_value("aw_count", NUM_XFER, aw_cnt);
        intr_total: assert (intr_cnt == NUM_XFER)
            else report_value("intr_count", NUM_XFER, intr_cnt);
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: transfers did not complete within %0d ns", TIMEOUT_NS);
        $display("Errors: %0d value, %0d other", value_errs, other_errs + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- project.f
rtl/dmac_cfg_pkg.sv
rtl/dmac_axi_pkg.sv
rtl/dmac_fifo.sv
rtl/dmac_read.sv
rtl/dmac_write.sv
rtl/dmac_top.sv
tests/dmac_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= dmac_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
